// ==== rtl/div_pkg.sv ====
// ------------------------------
// shared types and constants for the divider
// imported by the RTL and the testbench
// ------------------------------
package div_pkg;

    typedef logic [63:0] bus64_t;

    // one operand word, seen whole or as two halves for the W forms
    typedef union packed {
        bus64_t full;
        struct packed {
            logic [31:0] hi;
            logic [31:0] lo;
        } half;
    } div_word_u;

    // wishbone word addresses
    localparam logic [2:0] DIV_ADR_DVND = 3'd0;
    localparam logic [2:0] DIV_ADR_DVSR = 3'd1;
    localparam logic [2:0] DIV_ADR_CTRL = 3'd2;
    localparam logic [2:0] DIV_ADR_STAT = 3'd3;
    localparam logic [2:0] DIV_ADR_QUO  = 3'd4;
    localparam logic [2:0] DIV_ADR_RMD  = 3'd5;

    // control word bits
    localparam int CTRL_SIGNED_BIT = 0;
    localparam int CTRL_W32_BIT    = 1;
    localparam int CTRL_KILL_BIT   = 2;

    // status word bits
    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_DONE_BIT = 1;

    // core iterations, 4 quotient bits each
    localparam int DIV_ITER_64 = 16;
    localparam int DIV_ITER_32 = 8;

endpackage

// ==== rtl/div_radix16_step.sv ====
// ------------------------------
// four restoring divide steps, combinational
// ------------------------------
`timescale 1ns/1ps

module div_radix16_step (
    input  div_pkg::bus64_t remanent_i,
    input  div_pkg::bus64_t dividend_quotient_i,
    input  div_pkg::bus64_t divisor_i,
    output div_pkg::bus64_t remanent_o,
    output div_pkg::bus64_t dividend_quotient_o
);
    import div_pkg::*;

    bus64_t rem_c [0:4];
    bus64_t dq_c  [0:4];

    assign rem_c[0] = remanent_i;
    assign dq_c[0]  = dividend_quotient_i;

    for (genvar k = 0; k < 4; k++) begin : g_bit
        logic [64:0] part;
        logic [64:0] diff;

        // shift pair left, top bit of part is the carry out of the remainder
        assign part = {rem_c[k], dq_c[k][63]};
        assign diff = part - {1'b0, divisor_i};

        // negative trial keeps the shifted remainder
        assign rem_c[k+1] = diff[64] ? part[63:0] : diff[63:0];
        assign dq_c[k+1]  = {dq_c[k][62:0], ~diff[64]};   // new quotient bit
    end

    assign remanent_o          = rem_c[4];
    assign dividend_quotient_o = dq_c[4];

endmodule

// ==== rtl/div_wb_slave.sv ====
// ------------------------------
// wishbone classic register block of the divider
// ------------------------------
`timescale 1ns/1ps

module div_wb_slave (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            wb_cyc_i,
    input  logic            wb_stb_i,
    input  logic            wb_we_i,
    input  logic [2:0]      wb_adr_i,
    input  div_pkg::bus64_t wb_dat_i,
    output div_pkg::bus64_t wb_dat_o,
    output logic            wb_ack_o,
    output logic            req_valid_o,
    output logic            req_signed_o,
    output logic            req_w32_o,
    output logic            kill_o,
    output div_pkg::bus64_t req_dvnd_o,
    output div_pkg::bus64_t req_dvsr_o,
    input  logic            req_ready_i,
    input  logic            res_valid_i,
    input  div_pkg::bus64_t res_quo_i,
    input  div_pkg::bus64_t res_rmd_i,
    input  logic            busy_i
);
    import div_pkg::*;

    logic   ack_q, req_valid_q, kill_q, done_q;
    logic   signed_q, w32_q;
    bus64_t dvnd_q, dvsr_q, quo_q, rmd_q, dat_q;
    bus64_t rd_data;
    logic   bus_req, ctrl_wr, start_wr, kill_wr, stat_rd, req_xfer;

    assign bus_req  = wb_cyc_i & wb_stb_i & ~ack_q;   // new cycle, not yet answered
    assign ctrl_wr  = bus_req & wb_we_i & (wb_adr_i == DIV_ADR_CTRL);
    assign kill_wr  = ctrl_wr & wb_dat_i[CTRL_KILL_BIT];
    assign start_wr = ctrl_wr & ~wb_dat_i[CTRL_KILL_BIT];
    assign stat_rd  = bus_req & ~wb_we_i & (wb_adr_i == DIV_ADR_STAT);
    assign req_xfer = req_valid_q & req_ready_i;

    always_comb begin
        rd_data = '0;
        case (wb_adr_i)
            DIV_ADR_STAT: begin
                // result on its way to us still counts as busy
                rd_data[STAT_BUSY_BIT] = req_valid_q | busy_i | res_valid_i;
                rd_data[STAT_DONE_BIT] = done_q;
            end
            DIV_ADR_QUO:  rd_data = quo_q;
            DIV_ADR_RMD:  rd_data = rmd_q;
            default:      rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ack_q       <= 1'b0;
            req_valid_q <= 1'b0;
            kill_q      <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            ack_q  <= (bus_req & ~start_wr) | req_xfer;  // start waits for prep
            kill_q <= kill_wr;
            if (req_xfer)
                req_valid_q <= 1'b0;
            else if (start_wr)
                req_valid_q <= 1'b1;
            if (kill_q)
                done_q <= 1'b0;
            else if (res_valid_i)
                done_q <= 1'b1;
            else if (stat_rd)
                done_q <= 1'b0;   // read clears
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_req & wb_we_i & (wb_adr_i == DIV_ADR_DVND))
            dvnd_q <= wb_dat_i;
        if (bus_req & wb_we_i & (wb_adr_i == DIV_ADR_DVSR))
            dvsr_q <= wb_dat_i;
        if (start_wr & ~req_valid_q) begin
            signed_q <= wb_dat_i[CTRL_SIGNED_BIT];
            w32_q    <= wb_dat_i[CTRL_W32_BIT];
        end
        if (res_valid_i) begin
            quo_q <= res_quo_i;
            rmd_q <= res_rmd_i;
        end
        if (bus_req & ~wb_we_i)
            dat_q <= rd_data;
    end

    assign wb_ack_o     = ack_q;
    assign wb_dat_o     = dat_q;
    assign req_valid_o  = req_valid_q;
    assign req_signed_o = signed_q;
    assign req_w32_o    = w32_q;
    assign req_dvnd_o   = dvnd_q;
    assign req_dvsr_o   = dvsr_q;
    assign kill_o       = kill_q;

    // one ack per strobe, even with start wait states
    a_ack_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_ack_o |=> !wb_ack_o);

endmodule

// ==== rtl/div_operand_prep.sv ====
// ------------------------------
// stage 1: operand magnitudes and flags
// ------------------------------
`timescale 1ns/1ps

module div_operand_prep (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            kill_i,
    input  logic            valid_i,
    input  logic            signed_i,
    input  logic            w32_i,
    input  div_pkg::bus64_t dvnd_i,
    input  div_pkg::bus64_t dvsr_i,
    output logic            ready_o,
    output logic            valid_o,
    output logic            w32_o,
    output logic            quo_neg_o,
    output logic            rmd_neg_o,
    output logic            dvsr_zero_o,
    output div_pkg::bus64_t dvnd_mag_o,
    output div_pkg::bus64_t dvsr_mag_o,
    output div_pkg::bus64_t dvnd_raw_o,
    input  logic            ready_i
);
    import div_pkg::*;

    div_word_u   dvnd_w, dvsr_w;
    div_word_u   dvnd_core;
    logic        dvnd_sign, dvsr_sign, dvsr_zero;
    logic [31:0] dvnd_mag32, dvsr_mag32;
    bus64_t      dvnd_mag64, dvsr_mag64;
    logic        valid_q;

    assign dvnd_w.full = dvnd_i;
    assign dvsr_w.full = dvsr_i;

    assign dvnd_sign = signed_i & (w32_i ? dvnd_w.half.lo[31] : dvnd_w.full[63]);
    assign dvsr_sign = signed_i & (w32_i ? dvsr_w.half.lo[31] : dvsr_w.full[63]);
    assign dvsr_zero = w32_i ? (dvsr_w.half.lo == 32'd0) : (dvsr_w.full == '0);

    assign dvnd_mag32 = dvnd_sign ? ~dvnd_w.half.lo + 32'd1 : dvnd_w.half.lo;
    assign dvsr_mag32 = dvsr_sign ? ~dvsr_w.half.lo + 32'd1 : dvsr_w.half.lo;
    assign dvnd_mag64 = dvnd_sign ? ~dvnd_i + 64'd1 : dvnd_i;
    assign dvsr_mag64 = dvsr_sign ? ~dvsr_i + 64'd1 : dvsr_i;

    // W dividend goes to the upper half, core then shifts only 32 bits
    assign dvnd_core.half.hi = w32_i ? dvnd_mag32 : dvnd_mag64[63:32];
    assign dvnd_core.half.lo = w32_i ? 32'd0 : dvnd_mag64[31:0];

    assign ready_o = ~valid_q | ready_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i)
            valid_q <= 1'b0;
        else if (kill_i)
            valid_q <= 1'b0;
        else if (ready_o)
            valid_q <= valid_i;
    end

    always_ff @(posedge clk_i) begin
        if (valid_i & ready_o) begin
            w32_o       <= w32_i;
            quo_neg_o   <= dvnd_sign ^ dvsr_sign;
            rmd_neg_o   <= dvnd_sign;     // remainder follows the dividend
            dvsr_zero_o <= dvsr_zero;
            dvnd_mag_o  <= dvnd_core.full;
            dvsr_mag_o  <= w32_i ? {32'd0, dvsr_mag32} : dvsr_mag64;
            dvnd_raw_o  <= dvnd_i;
        end
    end

    assign valid_o = valid_q;

endmodule

// ==== rtl/div_iter_stage.sv ====
// ------------------------------
// stage 2: iterative radix-16 divide core
// ------------------------------
`timescale 1ns/1ps

module div_iter_stage (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            kill_i,
    input  logic            valid_i,
    output logic            ready_o,
    input  logic            w32_i,
    input  logic            quo_neg_i,
    input  logic            rmd_neg_i,
    input  logic            dvsr_zero_i,
    input  div_pkg::bus64_t dvnd_mag_i,
    input  div_pkg::bus64_t dvsr_mag_i,
    input  div_pkg::bus64_t dvnd_raw_i,
    output logic            valid_o,
    output div_pkg::bus64_t rem_o,
    output div_pkg::bus64_t quo_o,
    output logic            w32_o,
    output logic            quo_neg_o,
    output logic            rmd_neg_o,
    output logic            dvsr_zero_o,
    output div_pkg::bus64_t dvnd_raw_o,
    input  logic            ready_i,
    output logic            busy_o
);
    import div_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_OP   = 2'd1;
    localparam logic [1:0] ST_DONE = 2'd2;

    logic [1:0] state_q;
    logic [4:0] cnt_q;
    bus64_t     rem_q, dq_q, dvsr_q;
    bus64_t     step_rem, step_dq;
    logic       load;

    div_radix16_step u_step (
        .remanent_i          (rem_q),
        .dividend_quotient_i (dq_q),
        .divisor_i           (dvsr_q),
        .remanent_o          (step_rem),
        .dividend_quotient_o (step_dq)
    );

    assign ready_o = (state_q == ST_IDLE);
    assign load    = valid_i & ready_o & ~kill_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else if (kill_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: if (load) begin
                    state_q <= ST_OP;
                    cnt_q   <= w32_i ? 5'(DIV_ITER_32) : 5'(DIV_ITER_64);
                end
                ST_OP: begin
                    cnt_q <= cnt_q - 5'd1;
                    if (cnt_q == 5'd1)
                        state_q <= ST_DONE;
                end
                ST_DONE: if (ready_i) state_q <= ST_IDLE;   // fix-up took it
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            rem_q       <= '0;
            dq_q        <= dvnd_mag_i;
            dvsr_q      <= dvsr_mag_i;
            w32_o       <= w32_i;
            quo_neg_o   <= quo_neg_i;
            rmd_neg_o   <= rmd_neg_i;
            dvsr_zero_o <= dvsr_zero_i;
            dvnd_raw_o  <= dvnd_raw_i;
        end else if (state_q == ST_OP) begin
            rem_q <= step_rem;
            dq_q  <= step_dq;
        end
    end

    assign valid_o = (state_q == ST_DONE);
    assign rem_o   = rem_q;
    assign quo_o   = dq_q;
    assign busy_o  = (state_q != ST_IDLE) | valid_i;   // queued op in prep counts too

    a_cnt_range: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cnt_q <= 5'(DIV_ITER_64));
    a_valid_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_o && !ready_i && !kill_i |=> valid_o && $stable(quo_o) && $stable(rem_o));

endmodule

// ==== rtl/div_result_fix.sv ====
// ------------------------------
// stage 3: sign restore and special cases
// ------------------------------
`timescale 1ns/1ps

module div_result_fix (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            kill_i,
    input  logic            valid_i,
    output logic            ready_o,
    input  div_pkg::bus64_t rem_i,
    input  div_pkg::bus64_t quo_i,
    input  logic            w32_i,
    input  logic            quo_neg_i,
    input  logic            rmd_neg_i,
    input  logic            dvsr_zero_i,
    input  div_pkg::bus64_t dvnd_raw_i,
    output logic            res_valid_o,
    output div_pkg::bus64_t res_quo_o,
    output div_pkg::bus64_t res_rmd_o
);
    import div_pkg::*;

    bus64_t    quo_signed, rmd_signed;
    div_word_u quo_w, rmd_w;
    bus64_t    quo_final, rmd_final;
    logic      res_valid_q;

    assign quo_signed = quo_neg_i ? ~quo_i + 64'd1 : quo_i;
    assign rmd_signed = rmd_neg_i ? ~rem_i + 64'd1 : rem_i;

    // divide by zero: all ones and the dividend back
    assign quo_w.full = dvsr_zero_i ? '1 : quo_signed;
    assign rmd_w.full = dvsr_zero_i ? dvnd_raw_i : rmd_signed;

    assign quo_final = w32_i ? {{32{quo_w.half.lo[31]}}, quo_w.half.lo} : quo_w.full;
    assign rmd_final = w32_i ? {{32{rmd_w.half.lo[31]}}, rmd_w.half.lo} : rmd_w.full;

    // at most one result per two cycles, keeps res_valid a pulse
    assign ready_o = ~res_valid_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i)
            res_valid_q <= 1'b0;
        else
            res_valid_q <= valid_i & ready_o & ~kill_i;
    end

    always_ff @(posedge clk_i) begin
        if (valid_i & ready_o) begin
            res_quo_o <= quo_final;
            res_rmd_o <= rmd_final;
        end
    end

    assign res_valid_o = res_valid_q;

endmodule

// ==== rtl/div_top.sv ====
// ------------------------------
// divider top: wishbone slave and three stages
// ------------------------------
`timescale 1ns/1ps

module div_top (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            wb_cyc_i,
    input  logic            wb_stb_i,
    input  logic            wb_we_i,
    input  logic [2:0]      wb_adr_i,
    input  div_pkg::bus64_t wb_dat_i,
    output div_pkg::bus64_t wb_dat_o,
    output logic            wb_ack_o
);
    import div_pkg::*;

    logic   kill;
    logic   req_valid, req_ready, req_signed, req_w32;
    bus64_t req_dvnd, req_dvsr;
    logic   prep_valid, prep_ready, prep_w32, prep_quo_neg, prep_rmd_neg, prep_zero;
    bus64_t prep_dvnd_mag, prep_dvsr_mag, prep_dvnd_raw;
    logic   iter_valid, iter_ready, iter_w32, iter_quo_neg, iter_rmd_neg, iter_zero;
    bus64_t iter_rem, iter_quo, iter_dvnd_raw;
    logic   iter_busy;
    logic   res_valid;
    bus64_t res_quo, res_rmd;

    div_wb_slave u_slave (
        .clk_i (clk_i), .rstn_i (rstn_i),
        .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_we_i (wb_we_i),
        .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o), .wb_ack_o (wb_ack_o),
        .req_valid_o (req_valid), .req_signed_o (req_signed), .req_w32_o (req_w32),
        .kill_o (kill), .req_dvnd_o (req_dvnd), .req_dvsr_o (req_dvsr),
        .req_ready_i (req_ready),
        .res_valid_i (res_valid), .res_quo_i (res_quo), .res_rmd_i (res_rmd),
        .busy_i (iter_busy)
    );

    div_operand_prep u_prep (
        .clk_i (clk_i), .rstn_i (rstn_i), .kill_i (kill),
        .valid_i (req_valid), .signed_i (req_signed), .w32_i (req_w32),
        .dvnd_i (req_dvnd), .dvsr_i (req_dvsr), .ready_o (req_ready),
        .valid_o (prep_valid), .w32_o (prep_w32), .quo_neg_o (prep_quo_neg),
        .rmd_neg_o (prep_rmd_neg), .dvsr_zero_o (prep_zero),
        .dvnd_mag_o (prep_dvnd_mag), .dvsr_mag_o (prep_dvsr_mag),
        .dvnd_raw_o (prep_dvnd_raw), .ready_i (prep_ready)
    );

    div_iter_stage u_iter (
        .clk_i (clk_i), .rstn_i (rstn_i), .kill_i (kill),
        .valid_i (prep_valid), .ready_o (prep_ready),
        .w32_i (prep_w32), .quo_neg_i (prep_quo_neg), .rmd_neg_i (prep_rmd_neg),
        .dvsr_zero_i (prep_zero), .dvnd_mag_i (prep_dvnd_mag),
        .dvsr_mag_i (prep_dvsr_mag), .dvnd_raw_i (prep_dvnd_raw),
        .valid_o (iter_valid), .rem_o (iter_rem), .quo_o (iter_quo),
        .w32_o (iter_w32), .quo_neg_o (iter_quo_neg), .rmd_neg_o (iter_rmd_neg),
        .dvsr_zero_o (iter_zero), .dvnd_raw_o (iter_dvnd_raw),
        .ready_i (iter_ready), .busy_o (iter_busy)
    );

    div_result_fix u_fix (
        .clk_i (clk_i), .rstn_i (rstn_i), .kill_i (kill),
        .valid_i (iter_valid), .ready_o (iter_ready),
        .rem_i (iter_rem), .quo_i (iter_quo), .w32_i (iter_w32),
        .quo_neg_i (iter_quo_neg), .rmd_neg_i (iter_rmd_neg),
        .dvsr_zero_i (iter_zero), .dvnd_raw_i (iter_dvnd_raw),
        .res_valid_o (res_valid), .res_quo_o (res_quo), .res_rmd_o (res_rmd)
    );

endmodule

// ==== testbench/div_ref_model.svh ====
// ------------------------------
// reference quotient and remainder, RISC-V M rules
// included inside the testbench module
// ------------------------------
`ifndef DIV_REF_MODEL_SVH
`define DIV_REF_MODEL_SVH

// W results are sign-extended from bit 31
function automatic bus64_t sext32(logic [31:0] v);
    return {{32{v[31]}}, v};
endfunction

function automatic bus64_t quotient_of(bus64_t a, bus64_t b, logic is_signed, logic w32);
    div_word_u wrd_a;
    div_word_u wrd_b;
    int        sa32, sb32;
    longint    sa64, sb64;
    wrd_a.full = a;
    wrd_b.full = b;
    sa32 = wrd_a.half.lo;
    sb32 = wrd_b.half.lo;
    sa64 = a;
    sb64 = b;
    if (w32) begin
        if (wrd_b.half.lo == 32'd0)
            return '1;
        if (!is_signed)
            return sext32(wrd_a.half.lo / wrd_b.half.lo);
        if (sa32 == 32'sh8000_0000 && sb32 == -1)
            return sext32(wrd_a.half.lo);     // overflow gives the dividend
        return sext32(sa32 / sb32);
    end
    if (b == '0)
        return '1;
    if (!is_signed)
        return a / b;
    if (sa64 == 64'sh8000_0000_0000_0000 && sb64 == -64'sd1)
        return a;
    return sa64 / sb64;
endfunction

function automatic bus64_t remainder_of(bus64_t a, bus64_t b, logic is_signed, logic w32);
    div_word_u wrd_a;
    div_word_u wrd_b;
    int        sa32, sb32;
    longint    sa64, sb64;
    wrd_a.full = a;
    wrd_b.full = b;
    sa32 = wrd_a.half.lo;
    sb32 = wrd_b.half.lo;
    sa64 = a;
    sb64 = b;
    if (w32) begin
        if (wrd_b.half.lo == 32'd0)
            return sext32(wrd_a.half.lo);
        if (!is_signed)
            return sext32(wrd_a.half.lo % wrd_b.half.lo);
        if (sa32 == 32'sh8000_0000 && sb32 == -1)
            return '0;
        return sext32(sa32 % sb32);       // sign follows the dividend
    end
    if (b == '0)
        return a;
    if (!is_signed)
        return a % b;
    if (sa64 == 64'sh8000_0000_0000_0000 && sb64 == -64'sd1)
        return '0;
    return sa64 % sb64;
endfunction

`endif

// ==== testbench/div_tb.sv ====
// ------------------------------
// testbench for div_top, directed and random divides over wishbone
// results checked against the reference model
// ------------------------------
`timescale 1ns/1ps

module div_tb;
    import div_pkg::*;

`include "div_ref_model.svh"

    localparam int SEED        = 1595;
    localparam int NUM_RANDOM  = 300;
    localparam int NUM_OPS     = NUM_RANDOM + 16;   // directed ops on top
    localparam int CYCLE_LIMIT = NUM_OPS * (DIV_ITER_64 + 40) + 500;

    logic       clk, rstn;
    logic       wb_cyc, wb_stb, wb_we;
    logic [2:0] wb_adr;
    bus64_t     wb_dat_w, wb_dat_r;
    logic       wb_ack;
    int         value_errs, other_errs;
    int         cycles;

    div_top dut0 (
        .clk_i    (clk),
        .rstn_i   (rstn),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, run stopped", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic release_reset();
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
    endtask

    task automatic wait_ack();
        @(posedge clk);
        while (!wb_ack)
            @(posedge clk);
    endtask

    task automatic write_reg(input logic [2:0] adr, input bus64_t data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        wait_ack();                 // start writes may stall here
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic read_reg(input logic [2:0] adr, output bus64_t data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        wait_ack();
        data = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic check_quo(input bus64_t got, input bus64_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED quo: got %h, expected %h", got, exp);
        end
    endtask

    task automatic check_rmd(input bus64_t got, input bus64_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED rmd: got %h, expected %h", got, exp);
        end
    endtask

    task automatic check_stat(input bus64_t got, input logic exp_busy, input logic exp_done);
        bus64_t exp;
        exp = '0;
        exp[STAT_BUSY_BIT] = exp_busy;
        exp[STAT_DONE_BIT] = exp_done;
        if (got !== exp) begin
            value_errs++;
            $display("FAILED stat: got %h, expected %h", got, exp);
        end
    endtask

    function automatic bus64_t ctrl_word(logic is_signed, logic w32, logic kill);
        bus64_t w;
        w = '0;
        w[CTRL_SIGNED_BIT] = is_signed;
        w[CTRL_W32_BIT]    = w32;
        w[CTRL_KILL_BIT]   = kill;
        return w;
    endfunction

    // mix of wide random words and corner values
    function automatic bus64_t pick_operand();
        int sel;
        sel = $urandom_range(0, 9);
        case (sel)
            0, 1, 2, 3: return {$urandom(), $urandom()};
            4:          return 64'($urandom_range(0, 15));
            5:          return -64'($urandom_range(1, 15));
            6:          return '0;
            7:          return '1;
            8:          return 64'h8000_0000_0000_0000;
            default:    return {$urandom(), 32'h8000_0000};   // W most negative
        endcase
    endfunction

    task automatic start_op(input bus64_t dvnd, input bus64_t dvsr,
                            input logic is_signed, input logic w32);
        write_reg(DIV_ADR_DVND, dvnd);
        write_reg(DIV_ADR_DVSR, dvsr);
        write_reg(DIV_ADR_CTRL, ctrl_word(is_signed, w32, 1'b0));
    endtask

    task automatic poll_done(output logic ok);
        bus64_t stat;
        int     n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < 200) begin
            read_reg(DIV_ADR_STAT, stat);
            ok = stat[STAT_DONE_BIT];
            n++;
        end
        if (!ok) begin
            other_errs++;
            $display("done bit never set after %0d status reads", n);
        end
    endtask

    task automatic read_results(input bus64_t dvnd, input bus64_t dvsr,
                                input logic is_signed, input logic w32);
        bus64_t quo, rmd;
        read_reg(DIV_ADR_QUO, quo);
        check_quo(quo, quotient_of(dvnd, dvsr, is_signed, w32));
        read_reg(DIV_ADR_RMD, rmd);
        check_rmd(rmd, remainder_of(dvnd, dvsr, is_signed, w32));
    endtask

    task automatic run_single(input bus64_t dvnd, input bus64_t dvsr,
                              input logic is_signed, input logic w32);
        bus64_t stat;
        logic   ok;
        start_op(dvnd, dvsr, is_signed, w32);
        read_reg(DIV_ADR_STAT, stat);
        check_stat(stat, 1'b1, 1'b0);
        poll_done(ok);
        if (ok) begin
            read_results(dvnd, dvsr, is_signed, w32);
            read_reg(DIV_ADR_STAT, stat);
            check_stat(stat, 1'b0, 1'b0);   // done cleared by the read
        end
    endtask

    task automatic run_kill();
        bus64_t stat;
        start_op(pick_operand(), 64'd3, 1'b0, 1'b0);
        read_reg(DIV_ADR_STAT, stat);
        check_stat(stat, 1'b1, 1'b0);
        write_reg(DIV_ADR_CTRL, ctrl_word(1'b0, 1'b0, 1'b1));
        read_reg(DIV_ADR_STAT, stat);
        check_stat(stat, 1'b0, 1'b0);
        repeat (2 * DIV_ITER_64) @(posedge clk);   // no late result may show up
        read_reg(DIV_ADR_STAT, stat);
        check_stat(stat, 1'b0, 1'b0);
    endtask

    // third start reuses the second's operands, so it stalls behind a full prep
    task automatic run_queue();
        bus64_t dvnd [3];
        bus64_t dvsr [3];
        logic   sgn [3];
        bus64_t stat;
        logic   ok;
        int     i;
        for (i = 0; i < 2; i++) begin
            dvnd[i] = pick_operand();
            dvsr[i] = pick_operand();
            sgn[i]  = 1'($urandom_range(0, 1));
            start_op(dvnd[i], dvsr[i], sgn[i], 1'b0);
        end
        dvnd[2] = dvnd[1];
        dvsr[2] = dvsr[1];
        sgn[2]  = ~sgn[1];
        write_reg(DIV_ADR_CTRL, ctrl_word(sgn[2], 1'b0, 1'b0));
        for (i = 0; i < 3; i++) begin
            poll_done(ok);
            if (ok)
                read_results(dvnd[i], dvsr[i], sgn[i], 1'b0);
        end
        read_reg(DIV_ADR_STAT, stat);
        check_stat(stat, 1'b0, 1'b0);
    endtask

    initial begin
        bus64_t stat;
        logic   s, w;
        int     m, k;
        value_errs = 0;
        other_errs = 0;
        cycles     = 0;
        rstn       = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        void'($urandom(SEED));
        release_reset();

        read_reg(DIV_ADR_STAT, stat);
        check_stat(stat, 1'b0, 1'b0);

        run_single(64'd100, 64'd7, 1'b0, 1'b0);
        run_single(64'h8000_0000_0000_0000, '1, 1'b1, 1'b0);   // signed overflow
        run_single(-64'd7, 64'd2, 1'b1, 1'b0);
        run_single(64'd7, -64'd2, 1'b1, 1'b0);
        run_single(-64'd7, -64'd2, 1'b1, 1'b0);
        run_single(64'h1234_5678_8000_0000, 64'hdead_beef_ffff_ffff, 1'b1, 1'b1);
        for (m = 0; m < 4; m++)
            run_single(pick_operand(), '0, m[0], m[1]);        // zero divisor, each mode
        run_single(pick_operand(), 64'hffff_0000_0000_0000, 1'b0, 1'b1);

        run_kill();
        run_single(pick_operand(), pick_operand(), 1'b1, 1'b0);
        run_queue();

        for (k = 0; k < NUM_RANDOM; k++) begin
            s = 1'($urandom_range(0, 1));
            w = 1'($urandom_range(0, 1));
            run_single(pick_operand(), pick_operand(), s, w);
        end

        $display("checks done: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== div_core.f ====
+incdir+testbench
rtl/div_pkg.sv
rtl/div_radix16_step.sv
rtl/div_wb_slave.sv
rtl/div_operand_prep.sv
rtl/div_iter_stage.sv
rtl/div_result_fix.sv
rtl/div_top.sv
testbench/div_tb.sv

// ==== Makefile ====
# Verilator build and run of the divider testbench

VERILATOR ?= verilator
TOP       ?= div_tb
FILELIST  ?= div_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

FAIL_MSG := Result: FAILED
PASS_MSG := Result: PASSED

SIM_BIN := $(BUILD_DIR)/$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard testbench/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
